// ==== flist.f ====
+incdir+common
common/getir_pkg.sv
design/ps_kuyrugu.sv
design/getir1.sv
design/getir2.sv
design/getir_ust.sv
bench/tb_getir_ust.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f flist.f \
    --top-module tb_getir_ust \
    -o tb_getir_ust

./obj_dir/tb_getir_ust > sim.log 2>&1
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== bench/tb_getir_ust.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "getir_consts.svh"

module tb_getir_ust;

    import getir_pkg::*;

    localparam logic [`BUYRUK_BIT-1:0] IMZA = 32'hA5C3_0F96;
    localparam int ZAMAN_SINIRI = 200;

    logic                   clk_i = 1'b0;
    logic                   rst_n_i = 1'b0;
    yonlendirme_t           ddb_yon_i = '0;
    yonlendirme_t           yurut_yon_i = '0;
    logic [`PS_BIT-1:0]     istek_adres_o;
    logic                   istek_gecerli_o;
    logic                   istek_hazir_i = 1'b1;
    logic [`BUYRUK_BIT-1:0] yanit_veri_i = '0;
    logic                   yanit_gecerli_i = 1'b0;
    logic                   yanit_hazir_o;
    buyruk_paketi_t         coz_paket_o;
    logic                   coz_gecerli_o;
    logic                   coz_hazir_i = 1'b1;

    // Cache model state
    logic [`PS_BIT-1:0]     adres_k [$];
    int                     gecikme_k [$];
    logic                   istek_aktarildi = 1'b0;
    logic                   yanit_aktarildi = 1'b0;
    logic [`PS_BIT-1:0]     istek_adres_ornek = '0;
    logic [31:0]            lcg_durum = 32'd53;
    logic                   ilk_goruldu = 1'b0;
    logic [`PS_BIT-1:0]     ilk_adres = '0;

    // Every instruction accepted by decode in order
    buyruk_paketi_t         alinan [$];
    int                     okunan = 0;
    logic [`PS_BIT-1:0]     sonraki_ps;
    int                     kontrol_sayisi = 0;
    int                     hata_sayisi = 0;

    getir_ust u_getir_ust (
        .clk_i           ( clk_i ),
        .rst_n_i         ( rst_n_i ),
        .ddb_yon_i       ( ddb_yon_i ),
        .yurut_yon_i     ( yurut_yon_i ),
        .istek_adres_o   ( istek_adres_o ),
        .istek_gecerli_o ( istek_gecerli_o ),
        .istek_hazir_i   ( istek_hazir_i ),
        .yanit_veri_i    ( yanit_veri_i ),
        .yanit_gecerli_i ( yanit_gecerli_i ),
        .yanit_hazir_o   ( yanit_hazir_o ),
        .coz_paket_o     ( coz_paket_o ),
        .coz_gecerli_o   ( coz_gecerli_o ),
        .coz_hazir_i     ( coz_hazir_i )
    );

    initial begin
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    function automatic logic [31:0] lcg_sonraki();
        lcg_durum = lcg_durum * 32'd1103515245 + 32'd12345;
        return lcg_durum >> 16;
    endfunction

    // In-order cache with 0 to 3 cycles of latency per response
    always @(negedge clk_i) begin
        if (yanit_aktarildi) begin
            adres_k.delete(0);
            gecikme_k.delete(0);
            yanit_gecerli_i = 1'b0;
        end
        if (istek_aktarildi) begin
            adres_k.push_back(istek_adres_ornek);
            gecikme_k.push_back(int'(lcg_sonraki() % 32'd4));
        end
        if (!yanit_gecerli_i && adres_k.size() > 0) begin
            if (gecikme_k[0] == 0) begin
                yanit_gecerli_i = 1'b1;
                yanit_veri_i    = adres_k[0] ^ IMZA;
            end else begin
                gecikme_k[0] = gecikme_k[0] - 1;
            end
        end
        // Sample what the next rising edge will transfer
        #1;
        istek_aktarildi   = rst_n_i && istek_gecerli_o && istek_hazir_i;
        istek_adres_ornek = istek_adres_o;
        yanit_aktarildi   = rst_n_i && yanit_gecerli_i && yanit_hazir_o;
        if (rst_n_i && coz_gecerli_o && coz_hazir_i) begin
            alinan.push_back(coz_paket_o);
        end
        if (rst_n_i && !ilk_goruldu && istek_gecerli_o) begin
            ilk_goruldu = 1'b1;
            ilk_adres   = istek_adres_o;
        end
    end

    task automatic karsilastir_paket(input buyruk_paketi_t gercek,
                                     input buyruk_paketi_t beklenen, input string ne);
        kontrol_sayisi++;
        if (gercek !== beklenen) begin
            hata_sayisi++;
            $display("** Error at %0t ns: %s: got ps %h word %h, expected ps %h word %h",
                     $time, ne, gercek.ps, gercek.buyruk, beklenen.ps, beklenen.buyruk);
        end
    endtask

    task automatic karsilastir_ps(input logic [`PS_BIT-1:0] gercek,
                                  input logic [`PS_BIT-1:0] beklenen, input string ne);
        kontrol_sayisi++;
        if (gercek !== beklenen) begin
            hata_sayisi++;
            $display("** Error at %0t ns: %s: got %h, expected %h",
                     $time, ne, gercek, beklenen);
        end
    endtask

    task automatic karsilastir_bit(input logic gercek, input logic beklenen,
                                   input string ne);
        kontrol_sayisi++;
        if (gercek !== beklenen) begin
            hata_sayisi++;
            $display("** Error at %0t ns: %s: got %b, expected %b",
                     $time, ne, gercek, beklenen);
        end
    endtask

    task automatic zaman_asimi(input string ne);
        $display("Timeout at %0t ns: %s", $time, ne);
        $display("checks: %0d, errors: %0d", kontrol_sayisi, hata_sayisi + 1);
        $display("CHECKS FAILED");
        $finish;
    endtask

    task automatic cikis_bekle(output buyruk_paketi_t p);
        int sayac;
        sayac = 0;
        while (okunan >= alinan.size() && sayac < ZAMAN_SINIRI) begin
            @(negedge clk_i);
            sayac++;
        end
        if (okunan >= alinan.size()) begin
            zaman_asimi("no instruction reached decode");
        end else begin
            p = alinan[okunan];
            okunan++;
        end
    endtask

    // Expect adet outputs stepping from baslangic with word = ps ^ IMZA
    task automatic dizi_kontrol(input logic [`PS_BIT-1:0] baslangic, input int adet,
                                input string ne);
        buyruk_paketi_t gercek;
        buyruk_paketi_t beklenen;
        logic [`PS_BIT-1:0] ps;
        ps = baslangic;
        for (int i = 0; i < adet; i++) begin
            cikis_bekle(gercek);
            beklenen.ps     = ps;
            beklenen.buyruk = ps ^ IMZA;
            karsilastir_paket(gercek, beklenen, ne);
            ps = ps + `BUYRUK_ADIM;
        end
        sonraki_ps = ps;
    endtask

    function automatic yonlendirme_t hedef_yon(input logic [`PS_BIT-1:0] hedef);
        yonlendirme_t y;
        y.ps      = hedef;
        y.gecerli = 1'b1;
        return y;
    endfunction

    // One-cycle pulse; outputs accepted up to the epoch change are skipped
    task automatic yonlendir(input yonlendirme_t ddb, input yonlendirme_t yurut);
        @(negedge clk_i);
        ddb_yon_i   = ddb;
        yurut_yon_i = yurut;
        @(negedge clk_i);
        ddb_yon_i   = '0;
        yurut_yon_i = '0;
        okunan      = alinan.size();
    endtask

    task automatic test_bitti(input string ad, input int onceki);
        $display("%s finished with %0d errors", ad, hata_sayisi - onceki);
    endtask

    task automatic sirali_getirme_testi();
        int onceki;
        onceki = hata_sayisi;
        dizi_kontrol(`BASLANGIC_PS, 8, "sequential fetch");
        if (!ilk_goruldu) begin
            hata_sayisi++;
            $display("No fetch request was seen after reset");
        end else begin
            karsilastir_ps(ilk_adres, `BASLANGIC_PS, "first request address");
        end
        test_bitti("sequential fetch", onceki);
    endtask

    task automatic geri_basinc_testi();
        int onceki;
        logic dustu;
        logic tutuldu;
        buyruk_paketi_t tutulan;
        onceki  = hata_sayisi;
        dustu   = 1'b0;
        tutuldu = 1'b0;
        tutulan = '0;
        @(negedge clk_i);
        coz_hazir_i = 1'b0;
        for (int i = 0; i < 20; i++) begin
            @(negedge clk_i);
            #1;
            if (!istek_gecerli_o) begin
                dustu = 1'b1;
            end
            if (tutuldu) begin
                if (!coz_gecerli_o) begin
                    hata_sayisi++;
                    $display("Held decode output lost its valid at %0t ns", $time);
                end else begin
                    karsilastir_paket(coz_paket_o, tutulan, "held output");
                end
            end else if (coz_gecerli_o) begin
                tutulan = coz_paket_o;
                tutuldu = 1'b1;
            end
            // A held item blocks further responses
            if (coz_gecerli_o) begin
                karsilastir_bit(yanit_hazir_o, 1'b0, "response ready while stalled");
            end
        end
        if (!dustu || !tutuldu) begin
            hata_sayisi++;
            $display("Stall did not fill the queue or no output was held");
        end
        @(negedge clk_i);
        coz_hazir_i = 1'b1;
        dizi_kontrol(sonraki_ps, 8, "sequence after stall");
        test_bitti("back-pressure", onceki);
    endtask

    task automatic yurut_yonlendirme_testi();
        int onceki;
        onceki = hata_sayisi;
        yonlendir('0, hedef_yon(32'h0000_2000));
        dizi_kontrol(32'h0000_2000, 8, "execute redirect");
        test_bitti("execute redirect", onceki);
    endtask

    task automatic esanli_yonlendirme_testi();
        int onceki;
        onceki = hata_sayisi;
        yonlendir(hedef_yon(32'h0000_3000), hedef_yon(32'h0000_4000));
        dizi_kontrol(32'h0000_3000, 6, "redirect priority");
        test_bitti("redirect priority", onceki);
    endtask

    task automatic ardisik_yonlendirme_testi();
        int onceki;
        int sayac;
        buyruk_paketi_t beklenen;
        onceki          = hata_sayisi;
        sayac           = 0;
        beklenen.ps     = 32'h0000_6000;
        beklenen.buyruk = 32'h0000_6000 ^ IMZA;
        @(negedge clk_i);
        coz_hazir_i = 1'b0;
        yonlendir('0, hedef_yon(32'h0000_5000));
        repeat (2) @(negedge clk_i);
        yonlendir(hedef_yon(32'h0000_6000), '0);
        // Only the second target may show up while decode is stalled
        while (!coz_gecerli_o && sayac < ZAMAN_SINIRI) begin
            @(negedge clk_i);
            #1;
            sayac++;
        end
        if (!coz_gecerli_o) begin
            zaman_asimi("no output held after back-to-back redirects");
        end else begin
            karsilastir_paket(coz_paket_o, beklenen, "held output after redirects");
        end
        @(negedge clk_i);
        coz_hazir_i = 1'b1;
        dizi_kontrol(32'h0000_6000, 8, "back-to-back redirects");
        test_bitti("back-to-back redirects", onceki);
    endtask

    initial begin
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        sirali_getirme_testi();
        geri_basinc_testi();
        yurut_yonlendirme_testi();
        esanli_yonlendirme_testi();
        ardisik_yonlendirme_testi();
        $display("checks: %0d, errors: %0d", kontrol_sayisi, hata_sayisi);
        if (hata_sayisi == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/getir_ust.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "getir_consts.svh"

module getir_ust (
    input  wire                           clk_i,
    input  wire                           rst_n_i,

    // Redirect sources
    input  getir_pkg::yonlendirme_t       ddb_yon_i,
    input  getir_pkg::yonlendirme_t       yurut_yon_i,

    // L1 instruction cache request
    output logic [`PS_BIT-1:0]            istek_adres_o,
    output logic                          istek_gecerli_o,
    input  wire                           istek_hazir_i,

    // L1 instruction cache response
    input  wire  [`BUYRUK_BIT-1:0]        yanit_veri_i,
    input  wire                           yanit_gecerli_i,
    output logic                          yanit_hazir_o,

    // Decode
    output getir_pkg::buyruk_paketi_t     coz_paket_o,
    output logic                          coz_gecerli_o,
    input  wire                           coz_hazir_i
);

    import getir_pkg::*;

    ps_girdisi_t            kuyruk_yaz;
    logic                   kuyruk_yaz_gecerli;
    ps_girdisi_t            kuyruk_bas;
    logic                   kuyruk_oku;
    logic                   kuyruk_dolu;
    logic                   kuyruk_bos;
    logic [`DONEM_BIT-1:0]  donem;

    getir1 u_getir1 (
        .clk_i                  ( clk_i ),
        .rst_n_i                ( rst_n_i ),
        .ddb_yon_i              ( ddb_yon_i ),
        .yurut_yon_i            ( yurut_yon_i ),
        .istek_adres_o          ( istek_adres_o ),
        .istek_gecerli_o        ( istek_gecerli_o ),
        .istek_hazir_i          ( istek_hazir_i ),
        .kuyruk_yaz_o           ( kuyruk_yaz ),
        .kuyruk_yaz_gecerli_o   ( kuyruk_yaz_gecerli ),
        .kuyruk_dolu_i          ( kuyruk_dolu ),
        .kuyruk_bos_i           ( kuyruk_bos ),
        .donem_o                ( donem )
    );

    ps_kuyrugu #(
        .DERINLIK               ( `PS_KUYRUK_DERINLIK )
    ) u_ps_kuyrugu (
        .clk_i                  ( clk_i ),
        .rst_n_i                ( rst_n_i ),
        .yaz_i                  ( kuyruk_yaz ),
        .yaz_gecerli_i          ( kuyruk_yaz_gecerli ),
        .oku_o                  ( kuyruk_bas ),
        .oku_i                  ( kuyruk_oku ),
        .dolu_o                 ( kuyruk_dolu ),
        .bos_o                  ( kuyruk_bos )
    );

    getir2 u_getir2 (
        .clk_i                  ( clk_i ),
        .rst_n_i                ( rst_n_i ),
        .kuyruk_bas_i           ( kuyruk_bas ),
        .kuyruk_bos_i           ( kuyruk_bos ),
        .kuyruk_oku_o           ( kuyruk_oku ),
        .donem_i                ( donem ),
        .yanit_veri_i           ( yanit_veri_i ),
        .yanit_gecerli_i        ( yanit_gecerli_i ),
        .yanit_hazir_o          ( yanit_hazir_o ),
        .coz_paket_o            ( coz_paket_o ),
        .coz_gecerli_o          ( coz_gecerli_o ),
        .coz_hazir_i            ( coz_hazir_i )
    );

endmodule

`default_nettype wire

// ==== design/getir2.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "getir_consts.svh"

module getir2 (
    input  wire                           clk_i,
    input  wire                           rst_n_i,

    // Head of the pending program counter queue
    input  getir_pkg::ps_girdisi_t        kuyruk_bas_i,
    input  wire                           kuyruk_bos_i,
    output logic                          kuyruk_oku_o,

    input  wire  [`DONEM_BIT-1:0]         donem_i,

    input  wire  [`BUYRUK_BIT-1:0]        yanit_veri_i,
    input  wire                           yanit_gecerli_i,
    output logic                          yanit_hazir_o,

    output getir_pkg::buyruk_paketi_t     coz_paket_o,
    output logic                          coz_gecerli_o,
    input  wire                           coz_hazir_i
);

    import getir_pkg::*;

    buyruk_paketi_t         paket_q;
    logic [`DONEM_BIT-1:0]  paket_donem_q;
    logic                   dolu_q;
    logic                   eski;
    logic                   yanit_aktarim;
    logic                   donem_tutar;

    // Held item from an abandoned path
    assign eski = dolu_q && (paket_donem_q != donem_i);

    assign coz_gecerli_o = dolu_q && !eski;
    assign coz_paket_o   = paket_q;

    // Room when empty, stale, or being taken by decode
    assign yanit_hazir_o = !coz_gecerli_o || coz_hazir_i;

    assign yanit_aktarim = yanit_gecerli_i && yanit_hazir_o;
    assign kuyruk_oku_o  = yanit_aktarim && !kuyruk_bos_i;
    assign donem_tutar   = (kuyruk_bas_i.donem == donem_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dolu_q <= 1'b0;
        end else if (kuyruk_oku_o && donem_tutar) begin
            dolu_q <= 1'b1;
        end else if (eski || (coz_gecerli_o && coz_hazir_i)) begin
            dolu_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (kuyruk_oku_o && donem_tutar) begin
            paket_q.buyruk <= yanit_veri_i;
            paket_q.ps     <= kuyruk_bas_i.ps;
            paket_donem_q  <= kuyruk_bas_i.donem;
        end
    end

endmodule

`default_nettype wire

// ==== design/getir1.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "getir_consts.svh"

module getir1 (
    input  wire                           clk_i,
    input  wire                           rst_n_i,

    input  getir_pkg::yonlendirme_t       ddb_yon_i,
    input  getir_pkg::yonlendirme_t       yurut_yon_i,

    output logic [`PS_BIT-1:0]            istek_adres_o,
    output logic                          istek_gecerli_o,
    input  wire                           istek_hazir_i,

    output getir_pkg::ps_girdisi_t        kuyruk_yaz_o,
    output logic                          kuyruk_yaz_gecerli_o,
    input  wire                           kuyruk_dolu_i,
    input  wire                           kuyruk_bos_i,

    output logic [`DONEM_BIT-1:0]         donem_o
);

    import getir_pkg::*;

    yonlendirme_t           secilen_yon;
    logic [`PS_BIT-1:0]     ps_q;
    logic [`DONEM_BIT-1:0]  donem_q;
    logic                   bosaltiliyor_q;
    logic                   istek_aktarim;

    // Control and status unit wins over execute
    always_comb begin
        if (ddb_yon_i.gecerli) begin
            secilen_yon = ddb_yon_i;
        end else begin
            secilen_yon = yurut_yon_i;
        end
    end

    // No new fetch while the queue is full or old-path entries remain
    assign istek_gecerli_o = !kuyruk_dolu_i && !bosaltiliyor_q;
    assign istek_adres_o   = ps_q;
    assign istek_aktarim   = istek_gecerli_o && istek_hazir_i;

    always_comb begin
        kuyruk_yaz_o.ps    = ps_q;
        kuyruk_yaz_o.donem = donem_q;
    end

    assign kuyruk_yaz_gecerli_o = istek_aktarim;
    assign donem_o              = donem_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ps_q <= `BASLANGIC_PS;
        end else if (secilen_yon.gecerli) begin
            ps_q <= secilen_yon.ps;
        end else if (istek_aktarim) begin
            ps_q <= ps_q + `PS_BIT'(`BUYRUK_ADIM);
        end
    end

    // Epoch flips once per redirect burst, then wait for the queue to empty
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            donem_q        <= '0;
            bosaltiliyor_q <= 1'b0;
        end else if (secilen_yon.gecerli) begin
            if (!bosaltiliyor_q) begin
                donem_q        <= donem_q + 1'b1;
                bosaltiliyor_q <= 1'b1;
            end
        end else if (bosaltiliyor_q && kuyruk_bos_i) begin
            bosaltiliyor_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== design/ps_kuyrugu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "getir_consts.svh"

module ps_kuyrugu #(
    parameter int DERINLIK = `PS_KUYRUK_DERINLIK
) (
    input  wire                           clk_i,
    input  wire                           rst_n_i,

    input  getir_pkg::ps_girdisi_t        yaz_i,
    input  wire                           yaz_gecerli_i,

    output getir_pkg::ps_girdisi_t        oku_o,
    input  wire                           oku_i,

    output logic                          dolu_o,
    output logic                          bos_o
);

    import getir_pkg::*;

    localparam int IMLEC_BIT = $clog2(DERINLIK);
    localparam int SAYAC_BIT = $clog2(DERINLIK + 1);

    ps_girdisi_t            bellek [DERINLIK];
    logic [IMLEC_BIT-1:0]   yaz_imlec_q;
    logic [IMLEC_BIT-1:0]   oku_imlec_q;
    logic [SAYAC_BIT-1:0]   sayac_q;
    logic                   yaz;
    logic                   oku;

    assign dolu_o = (sayac_q == SAYAC_BIT'(DERINLIK));
    assign bos_o  = (sayac_q == '0);

    assign yaz = yaz_gecerli_i && !dolu_o;
    assign oku = oku_i && !bos_o;

    // Oldest pending entry
    assign oku_o = bellek[oku_imlec_q];

    always_ff @(posedge clk_i) begin
        if (yaz) begin
            bellek[yaz_imlec_q] <= yaz_i;
        end
    end

    // Pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            yaz_imlec_q <= '0;
            oku_imlec_q <= '0;
            sayac_q     <= '0;
        end else begin
            if (yaz) begin
                yaz_imlec_q <= yaz_imlec_q + 1'b1;
            end
            if (oku) begin
                oku_imlec_q <= oku_imlec_q + 1'b1;
            end
            case ({yaz, oku})
                2'b10:   sayac_q <= sayac_q + 1'b1;
                2'b01:   sayac_q <= sayac_q - 1'b1;
                default: sayac_q <= sayac_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== common/getir_pkg.sv ====
`default_nettype none

`include "getir_consts.svh"

package getir_pkg;

    // Redirect request from a later stage
    typedef struct packed {
        logic [`PS_BIT-1:0]     ps;
        logic                   gecerli;
    } yonlendirme_t;

    // One pending fetch, tagged with the epoch it was issued in
    typedef struct packed {
        logic [`PS_BIT-1:0]     ps;
        logic [`DONEM_BIT-1:0]  donem;
    } ps_girdisi_t;

    // Instruction word and its program counter, towards decode
    typedef struct packed {
        logic [`BUYRUK_BIT-1:0] buyruk;
        logic [`PS_BIT-1:0]     ps;
    } buyruk_paketi_t;

endpackage

`default_nettype wire

// ==== common/getir_consts.svh ====
`ifndef GETIR_CONSTS_SVH
`define GETIR_CONSTS_SVH

// Program counter and address width
`define PS_BIT              32

// Instruction word width
`define BUYRUK_BIT          32

// Fetch epoch width
`define DONEM_BIT           1

// Entries in the pending program counter queue
`define PS_KUYRUK_DERINLIK  4

// First fetch address after reset
`define BASLANGIC_PS        32'h0000_1000

// Step between sequential fetches
`define BUYRUK_ADIM         4

`endif
